//--- Makefile
TOP := pixel_link_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): pixel_link.f *.sv
	verilator --binary --timing --assert -Wno-fatal -f pixel_link.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f pixel_link.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- byte_fifo.sv
module byte_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  push,
    input  pixel_link_pkg::byte_t push_data,
    input  logic                  pop,
    output pixel_link_pkg::byte_t pop_data,
    output logic                  empty,
    output logic                  full
);
    import pixel_link_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    byte_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push_ok;
    logic             pop_ok;

    ////////////////////////////////////////////////////////////
    // Status and head
    ////////////////////////////////////////////////////////////

    assign empty = (count == '0);
    assign full  = (count == (PTR_W + 1)'(FIFO_DEPTH));

    // Writes into a full FIFO are lost
    assign push_ok = push & ~full;
    assign pop_ok  = pop & ~empty;

    // Fall-through head, valid whenever empty is low
    assign pop_data = mem[rd_ptr];

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop in one cycle cancel out
            if (push_ok && !pop_ok) begin
                count <= count + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

//--- frame_buffer.sv
module frame_buffer #(
    parameter int FRAME_W = 176,
    parameter int FRAME_H = 240
) (
    input  logic                                 clk,
    input  logic [$clog2(FRAME_W*FRAME_H)-1:0]   rd_addr,
    pixel_write_if.sink                          wr,
    output pixel_link_pkg::pixel_t               rd_data
);
    import pixel_link_pkg::*;

    localparam int PIXELS = FRAME_W * FRAME_H;

    ////////////////////////////////////////////////////////////
    // Pixel storage
    ////////////////////////////////////////////////////////////

    // One entry per pixel, row after row
    pixel_t mem [PIXELS];

    // Write port driven by the assembler
    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.rgb;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////

    // Registered read, one cycle of latency
    // Same-address write in this cycle is not visible yet
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- pixel_assembler.sv
module pixel_assembler #(
    parameter int FRAME_W = 176,
    parameter int FRAME_H = 240
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  empty,
    input  pixel_link_pkg::byte_t pop_data,
    output logic                  pop,
    pixel_write_if.source         wr
);
    import pixel_link_pkg::*;

    localparam int                PIXELS   = FRAME_W * FRAME_H;
    localparam int                ADDR_W   = $clog2(PIXELS);
    localparam logic [ADDR_W-1:0] LAST_PIX = ADDR_W'(PIXELS - 1);

    asm_state_t        state;
    asm_state_t        state_next;
    logic [ADDR_W-1:0] pixel_cnt;
    byte_t             red_q;
    byte_t             green_q;
    logic              take;
    logic              blue_take;
    logic              last_pix;

    ////////////////////////////////////////////////////////////
    // Byte consumption
    ////////////////////////////////////////////////////////////

    // Every state eats the head byte once it is there,
    // an empty FIFO simply stalls the FSM
    assign take = ~empty;
    assign pop  = take;

    // Third colour byte of a pixel is being taken
    assign blue_take = take && (state == BLUE);
    assign last_pix  = (pixel_cnt == LAST_PIX);

    ////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        if (take) begin
            case (state)
                HUNT: begin
                    // Anything but the sync byte is junk
                    if (pop_data == SYNC_BYTE) begin
                        state_next = RED;
                    end
                end
                RED: begin
                    state_next = GREEN;
                end
                GREEN: begin
                    state_next = BLUE;
                end
                BLUE: begin
                    // Back to hunting once the frame is full
                    if (last_pix) begin
                        state_next = HUNT;
                    end else begin
                        state_next = RED;
                    end
                end
                default: begin
                    state_next = HUNT;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= HUNT;
            pixel_cnt     <= '0;
            wr.we         <= 1'b0;
            wr.frame_done <= 1'b0;
        end else begin
            state         <= state_next;
            // One-cycle write strobe after the blue byte
            wr.we         <= blue_take;
            wr.frame_done <= blue_take && last_pix;
            if (blue_take) begin
                if (last_pix) begin
                    pixel_cnt <= '0;
                end else begin
                    pixel_cnt <= pixel_cnt + 1'b1;
                end
            end
        end
    end

    // Colour bytes and the outgoing pixel
    always_ff @(posedge clk) begin
        if (take && (state == RED)) begin
            red_q <= pop_data;
        end
        if (take && (state == GREEN)) begin
            green_q <= pop_data;
        end
        if (blue_take) begin
            wr.rgb  <= {red_q, green_q, pop_data};
            wr.addr <= pixel_cnt;
        end
    end

endmodule

//--- pixel_link.f
pixel_link_pkg.sv
pixel_write_if.sv
byte_fifo.sv
pixel_assembler.sv
frame_buffer.sv
pixel_link_top.sv
pixel_link_assertions.sv
pixel_link_tb.sv

//--- pixel_link_assertions.sv
module pixel_link_assertions #(
    parameter int FRAME_W = 176,
    parameter int FRAME_H = 240
) (
    input logic                               clk,
    input logic                               reset,
    input logic                               empty,
    input logic                               pop,
    input logic                               we,
    input logic                               frame_done,
    input logic [$clog2(FRAME_W*FRAME_H)-1:0] addr,
    input pixel_link_pkg::asm_state_t         state
);
    import pixel_link_pkg::*;

    localparam int PIXELS = FRAME_W * FRAME_H;

    ////////////////////////////////////////////////////////////
    // FIFO side
    ////////////////////////////////////////////////////////////

    pop_not_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("pop while the FIFO is empty");

    ////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////

    we_single: assert property (@(posedge clk) disable iff (reset) we |=> !we)
        else $error("write strobe high for two cycles");

    frame_done_with_we: assert property (@(posedge clk) disable iff (reset) frame_done |-> we)
        else $error("frame_done without a pixel write");

    addr_in_frame: assert property (@(posedge clk) disable iff (reset) we |-> int'(addr) < PIXELS)
        else $error("write address outside the frame");

    // Frame end sends the FSM back to sync hunting
    frame_end_hunt: assert property (@(posedge clk) disable iff (reset) frame_done |-> state == HUNT)
        else $error("FSM not hunting after the frame end");

endmodule

bind pixel_assembler pixel_link_assertions #(
    .FRAME_W (FRAME_W),
    .FRAME_H (FRAME_H)
) asm_chk_i (
    .clk        (clk),
    .reset      (reset),
    .empty      (empty),
    .pop        (pop),
    .we         (wr.we),
    .frame_done (wr.frame_done),
    .addr       (wr.addr),
    .state      (state)
);

//--- pixel_link_pkg.sv
package pixel_link_pkg;

    ////////////////////////////////////////////////////////////
    // Stream and pixel types
    ////////////////////////////////////////////////////////////

    // One byte of the incoming serial stream
    typedef logic [7:0] byte_t;

    // Packed RGB888 pixel
    // Red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] pixel_t;

    ////////////////////////////////////////////////////////////
    // Framing
    ////////////////////////////////////////////////////////////

    // Marks the start of a frame in the byte stream
    localparam byte_t SYNC_BYTE = 8'hAA;

    ////////////////////////////////////////////////////////////
    // Assembler FSM
    ////////////////////////////////////////////////////////////

    // HUNT drops bytes until the sync byte shows up,
    // then each pixel is three bytes in R, G, B order
    typedef enum logic [1:0] {
        HUNT,
        RED,
        GREEN,
        BLUE
    } asm_state_t;

endpackage

//--- pixel_link_tb.sv
module pixel_link_tb;
    import pixel_link_pkg::*;

    localparam int FRAME_W    = 4;
    localparam int FRAME_H    = 3;
    localparam int FIFO_DEPTH = 8;
    localparam int PIXELS     = FRAME_W * FRAME_H;
    localparam int ADDR_W     = $clog2(PIXELS);
    localparam int NUM_ROWS   = 3;

    ////////////////////////////////////////////////////////////
    // Test frames
    ////////////////////////////////////////////////////////////

    // Junk bytes sent ahead of the sync byte, one entry per frame
    localparam int JUNK_TBL [NUM_ROWS] = '{3, 0, 6};

    // Pixels of each frame in address order
    // AA inside a frame is plain colour data
    localparam pixel_t PIX_TBL [NUM_ROWS][PIXELS] = '{
        '{24'h102030, 24'h405060, 24'h708090, 24'hA0B0C0,
          24'hFF0000, 24'h00FF00, 24'h0000FF, 24'hAAAAAA,
          24'h123456, 24'h789ABC, 24'hDEF012, 24'h345678},
        '{24'h0F1E2D, 24'h3C4B5A, 24'h697887, 24'h96A5B4,
          24'hC3D2E1, 24'hF00F0F, 24'h11AA22, 24'h334455,
          24'h667788, 24'h99AABB, 24'hCCDDEE, 24'hFEDCBA},
        '{24'h010203, 24'h040506, 24'h070809, 24'h0A0B0C,
          24'hAA5500, 24'h55AA00, 24'h000000, 24'hFFFFFF,
          24'h808080, 24'h7F7F7F, 24'h13579B, 24'h2468AC}
    };

    logic              clk = 1'b0;
    logic              reset;
    logic              rx_valid;
    byte_t             rx_byte;
    logic              rx_ready;
    logic [ADDR_W-1:0] rd_addr;
    pixel_t            rd_data;
    logic              pixel_done;
    logic              frame_done;

    logic [31:0] rand_state = 32'h2707;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          pixel_count = 0;
    int          frames_seen = 0;

    pixel_link_top #(
        .FRAME_W    (FRAME_W),
        .FRAME_H    (FRAME_H),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut_i (
        .clk        (clk),
        .reset      (reset),
        .rx_valid   (rx_valid),
        .rx_byte    (rx_byte),
        .rx_ready   (rx_ready),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .pixel_done (pixel_done),
        .frame_done (frame_done)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    // One byte with an optional idle gap in front
    // Entered and left at a falling edge
    task automatic send_byte(input byte_t b);
        int gap;
        rand_state = xorshift32(rand_state);
        gap = rand_state[3] ? 0 : int'(rand_state[1:0]);
        repeat (gap) @(negedge clk);
        // FIFO never fills at this rate
        check_value("rx_ready", 32'(rx_ready), 32'd1);
        while (!rx_ready) begin
            @(negedge clk);
        end
        rx_valid = 1'b1;
        rx_byte  = b;
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic send_junk(input int row);
        byte_t junk;
        for (int i = 0; i < JUNK_TBL[row]; i++) begin
            rand_state = xorshift32(rand_state);
            junk = rand_state[15:8];
            if (junk == SYNC_BYTE) begin
                junk = 8'h55;
            end
            send_byte(junk);
        end
    endtask

    // Sync byte, then R, G, B of every pixel
    task automatic send_pixels(input int row);
        send_byte(SYNC_BYTE);
        for (int p = 0; p < PIXELS; p++) begin
            send_byte(PIX_TBL[row][p][23:16]);
            send_byte(PIX_TBL[row][p][15:8]);
            send_byte(PIX_TBL[row][p][7:0]);
        end
    endtask

    task automatic read_frame(input int row);
        for (int a = 0; a < PIXELS; a++) begin
            rd_addr = ADDR_W'(a);
            @(negedge clk);
            check_value($sformatf("rd_data[%0d]", a), 32'(rd_data), 32'(PIX_TBL[row][a]));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Output monitor and timeout
    ////////////////////////////////////////////////////////////

    // Registered outputs, sampled with their value from the cycle before the edge
    always @(posedge clk) begin
        if (!reset) begin
            if (pixel_done) begin
                pixel_count++;
            end
            if (frame_done) begin
                check_value("pixel_done pulses per frame", 32'(pixel_count), 32'(PIXELS));
                frames_seen++;
                pixel_count = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: frames did not complete within %0d cycles", cycle_limit);
            $display("checks %0d, errors %0d", check_count, error_count);
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int total_bytes;
        total_bytes = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total_bytes += JUNK_TBL[r] + 1 + 3 * PIXELS;
        end
        // Up to four cycles per byte, plus readback and drain time
        cycle_limit = 4 * total_bytes + NUM_ROWS * (2 * PIXELS + FIFO_DEPTH + 8) + 100;

        reset    = 1'b1;
        rx_valid = 1'b0;
        rx_byte  = '0;
        rd_addr  = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        check_value("rx_ready", 32'(rx_ready), 32'd1);
        check_value("pixel_done", 32'(pixel_done), 32'd0);
        check_value("frame_done", 32'(frame_done), 32'd0);

        for (int row = 0; row < NUM_ROWS; row++) begin
            send_junk(row);
            // Let the assembler drop whatever junk is still queued
            repeat (FIFO_DEPTH + 2) @(negedge clk);
            check_value("pixel_done pulses during junk", 32'(pixel_count), 32'd0);
            if (row > 0) begin
                read_frame(row - 1);
            end
            send_pixels(row);
            while (frames_seen < row + 1) begin
                @(negedge clk);
            end
            @(negedge clk);
            read_frame(row);
        end

        repeat (4) @(negedge clk);
        check_value("frame_done pulses", 32'(frames_seen), 32'(NUM_ROWS));

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- pixel_link_top.sv
module pixel_link_top #(
    parameter int FRAME_W    = 176,
    parameter int FRAME_H    = 240,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               rx_valid,
    input  pixel_link_pkg::byte_t              rx_byte,
    output logic                               rx_ready,
    input  logic [$clog2(FRAME_W*FRAME_H)-1:0] rd_addr,
    output pixel_link_pkg::pixel_t             rd_data,
    output logic                               pixel_done,
    output logic                               frame_done
);
    import pixel_link_pkg::*;

    // FIFO to assembler
    byte_t fifo_head;
    logic  fifo_empty;
    logic  fifo_full;
    logic  fifo_pop;

    // Assembler to frame buffer
    pixel_write_if #(
        .FRAME_W (FRAME_W),
        .FRAME_H (FRAME_H)
    ) wr_if ();

    ////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////

    // Source may push only while there is room
    assign rx_ready = ~fifo_full;

    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .reset     (reset),
        .push      (rx_valid),
        .push_data (rx_byte),
        .pop       (fifo_pop),
        .pop_data  (fifo_head),
        .empty     (fifo_empty),
        .full      (fifo_full)
    );

    pixel_assembler #(
        .FRAME_W (FRAME_W),
        .FRAME_H (FRAME_H)
    ) asm_i (
        .clk      (clk),
        .reset    (reset),
        .empty    (fifo_empty),
        .pop_data (fifo_head),
        .pop      (fifo_pop),
        .wr       (wr_if.source)
    );

    ////////////////////////////////////////////////////////////
    // Storage and status
    ////////////////////////////////////////////////////////////

    frame_buffer #(
        .FRAME_W (FRAME_W),
        .FRAME_H (FRAME_H)
    ) fb_i (
        .clk     (clk),
        .rd_addr (rd_addr),
        .wr      (wr_if.sink),
        .rd_data (rd_data)
    );

    assign pixel_done = wr_if.we;
    assign frame_done = wr_if.frame_done;

endmodule

//--- pixel_write_if.sv
interface pixel_write_if #(
    parameter int FRAME_W = 176,
    parameter int FRAME_H = 240
);
    import pixel_link_pkg::*;

    // Pixel address range follows the frame size
    localparam int ADDR_W = $clog2(FRAME_W * FRAME_H);

    logic              we;
    logic [ADDR_W-1:0] addr;
    pixel_t            rgb;
    // High together with the write of the last pixel
    logic              frame_done;

    // Assembler side
    modport source (output we, output addr, output rgb, output frame_done);

    // Frame buffer side
    modport sink (input we, input addr, input rgb, input frame_done);

endinterface
